/* build.f */
common/priv_pkg.sv
csr/csr_access.sv
csr/csr_file.sv
hdl/trap_unit.sv
hdl/priv_unit.sv
sim/tb_priv_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_priv_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_priv_unit.sv */
module tb_priv_unit;
   import priv_pkg::*;

   localparam int    RESP_TIMEOUT = 20;
   localparam xlen_t TRAP_BASE    = 32'h0000_0100;

   logic        clk;
   logic        rstn;
   logic        cmd_valid;
   sys_cmd_t    cmd;
   logic        ext_intr;
   logic        timer_intr;
   logic        resp_valid;
   sys_resp_t   resp;
   priv_mode_t  mode;

   // reference model state
   priv_mode_t  m_mode;
   logic        m_mie;
   logic        m_mpie;
   priv_mode_t  m_mpp;
   xlen_t       m_mie_reg;
   xlen_t       m_mtvec;
   xlen_t       m_mscratch;
   xlen_t       m_mepc;
   xlen_t       m_mcause;
   xlen_t       m_mtval;

   sys_resp_t   exp_resp;
   priv_mode_t  exp_mode;
   string       test_name;
   logic [63:0] cycle_count;
   logic [4:0]  uimm;
   int          gap;

   priv_unit #(
      .MTVEC_RESET (TRAP_BASE)
   ) uut (
      .clk        (clk),
      .rstn       (rstn),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .ext_intr   (ext_intr),
      .timer_intr (timer_intr),
      .resp_valid (resp_valid),
      .resp       (resp),
      .mode       (mode)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // cycles since reset as mcycle counts them
   always @(posedge clk) begin
      if (rstn) begin
         cycle_count <= '0;
      end else begin
         cycle_count <= cycle_count + 64'd1;
      end
   end

   ////////////////////////////////////////
   // checkers
   ////////////////////////////////////////
   a_resp_match: assert property (@(posedge clk) disable iff (rstn)
      resp_valid |-> resp == exp_resp)
   else begin
      $display("CHECK FAILED %s expected rd %h pc %h trap %b actual rd %h pc %h trap %b",
               test_name, exp_resp.rd_data, exp_resp.next_pc, exp_resp.trapped,
               resp.rd_data, resp.next_pc, resp.trapped);
      $display("Simulation failed");
      $fatal(1, "response mismatch");
   end

   a_mode_match: assert property (@(posedge clk) disable iff (rstn)
      resp_valid |-> mode == exp_mode)
   else begin
      $display("CHECK FAILED %s mode expected %0d actual %0d", test_name, exp_mode, mode);
      $display("Simulation failed");
      $fatal(1, "mode mismatch");
   end

   a_latency: assert property (@(posedge clk) disable iff (rstn)
      $past(cmd_valid, 2) |-> resp_valid)
   else begin
      $display("response did not arrive two cycles after the command in %s", test_name);
      $display("Simulation failed");
      $fatal(1, "latency");
   end

   a_no_stray: assert property (@(posedge clk) disable iff (rstn)
      resp_valid |-> $past(cmd_valid, 2))
   else begin
      $display("response without a command two cycles earlier in %s", test_name);
      $display("Simulation failed");
      $fatal(1, "stray response");
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic logic csr_exists(input csr_addr_t addr);
      return addr inside {MSTATUS, MISA, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP,
                          MCYCLE, MCYCLEH, MVENDORID, MARCHID, MIMPID, MHARTID};
   endfunction

   function automatic xlen_t csr_value(input csr_addr_t addr, input logic [63:0] cyc);
      xlen_t v;
      v = '0;
      case (addr)
         MSTATUS: begin
            if (m_mpp == MODE_M) begin
               v[12:11] = 2'b11;
            end
            v[7] = m_mpie;
            v[3] = m_mie;
         end
         // rv32 with I and U
         MISA:     v = 32'h4010_0100;
         MIE:      v = m_mie_reg;
         MIP:      v = {20'b0, ext_intr, 3'b0, timer_intr, 7'b0};
         MTVEC:    v = m_mtvec;
         MSCRATCH: v = m_mscratch;
         MEPC:     v = m_mepc;
         MCAUSE:   v = m_mcause;
         MTVAL:    v = m_mtval;
         MCYCLE:   v = cyc[31:0];
         MCYCLEH:  v = cyc[63:32];
         default:  v = '0;
      endcase
      return v;
   endfunction

   function automatic void apply_write(input csr_addr_t addr, input xlen_t v);
      case (addr)
         MSTATUS: begin
            m_mie  = v[3];
            m_mpie = v[7];
            m_mpp  = (v[12:11] == 2'b11) ? MODE_M : MODE_U;
         end
         MIE: m_mie_reg = v & 32'h0000_0888;
         MTVEC: begin
            if (v[1:0] < 2'd2) begin
               m_mtvec = v;
            end
         end
         MSCRATCH: m_mscratch = v;
         MEPC:     m_mepc = v;
         MCAUSE:   m_mcause = v;
         MTVAL:    m_mtval = v;
         default:  ;
      endcase
   endfunction

   // expected response and state change of one command
   function automatic void predict(input sys_cmd_t c, input logic [63:0] cyc);
      logic       csr_op;
      logic       ok;
      xlen_t      old;
      xlen_t      nv;
      logic       wr;
      xlen_t      pend;
      logic       irq;
      logic [4:0] code;
      logic       exc;
      logic [4:0] ecause;
      xlen_t      etval;
      xlen_t      base;
      csr_op = c.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
      ok = csr_exists(c.csr_addr);
      old = ok ? csr_value(c.csr_addr, cyc) : '0;
      case (c.op)
         OP_CSRRW, OP_CSRRWI: nv = c.src;
         OP_CSRRS, OP_CSRRSI: nv = old | c.src;
         OP_CSRRC, OP_CSRRCI: nv = old & ~c.src;
         default:             nv = old;
      endcase
      wr = csr_op && !(c.op inside {OP_CSRRS, OP_CSRRC, OP_CSRRSI, OP_CSRRCI}
                       && c.rs1_idx == 5'd0);
      // msip is never set here so external beats timer
      pend = '0;
      pend[11] = ext_intr;
      pend[7] = timer_intr;
      pend = pend & m_mie_reg;
      irq = (m_mode == MODE_U || m_mie) && pend != '0;
      code = pend[11] ? 5'd11 : 5'd7;
      exc = 1'b0;
      ecause = 5'd2;
      etval = c.instr;
      case (c.op)
         OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: exc = !ok;
         OP_ILLEGAL: exc = 1'b1;
         OP_MRET:    exc = (m_mode == MODE_U);
         OP_ECALL: begin
            exc = 1'b1;
            ecause = (m_mode == MODE_U) ? 5'd8 : 5'd11;
            etval = '0;
         end
         OP_EBREAK: begin
            exc = 1'b1;
            ecause = 5'd3;
            etval = '0;
         end
         default: ;
      endcase
      base = {m_mtvec[31:2], 2'b00};
      exp_resp.rd_data = csr_op ? old : '0;
      exp_resp.trapped = irq || exc;
      if (irq || exc) begin
         exp_resp.next_pc = (irq && m_mtvec[1:0] == 2'b01) ? base + 32'(code) * 32'd4 : base;
         m_mpie = m_mie;
         m_mie = 1'b0;
         m_mpp = m_mode;
         m_mode = MODE_M;
         m_mepc = c.pc;
         m_mcause = irq ? (32'h8000_0000 | 32'(code)) : 32'(ecause);
         m_mtval = irq ? '0 : etval;
      end else if (c.op == OP_MRET) begin
         exp_resp.next_pc = m_mepc;
         m_mie = m_mpie;
         m_mpie = 1'b1;
         m_mode = m_mpp;
         m_mpp = MODE_U;
      end else begin
         exp_resp.next_pc = c.pc + 32'd4;
         if (wr) begin
            apply_write(c.csr_addr, nv);
         end
      end
      exp_mode = m_mode;
   endfunction

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   function automatic xlen_t random_pc();
      return $urandom & 32'hffff_fffc;
   endfunction

   task automatic issue_cmd(input string name, input sys_op_t op, input csr_addr_t addr,
                            input logic [4:0] rs1, input xlen_t src, input xlen_t pc);
      sys_cmd_t c;
      int       waited;
      c.op = op;
      c.csr_addr = addr;
      c.rs1_idx = rs1;
      c.src = src;
      c.pc = pc;
      c.instr = $urandom;
      @(posedge clk);
      test_name = name;
      // mcycle as seen when the command is sampled one edge later
      predict(c, cycle_count + 64'd1);
      cmd <= c;
      cmd_valid <= 1'b1;
      @(posedge clk);
      cmd_valid <= 1'b0;
      waited = 0;
      while (!resp_valid && waited < RESP_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (!resp_valid) begin
         $display("no response for %s within %0d cycles", name, RESP_TIMEOUT);
         $display("Simulation failed");
         $fatal(1, "response timeout");
      end
   endtask

   task automatic read_csr(input string name, input csr_addr_t addr);
      issue_cmd(name, OP_CSRRS, addr, 5'd0, 32'h0, random_pc());
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   ////////////////////////////////////////
   // directed sequence
   ////////////////////////////////////////
   initial begin
      void'($urandom(32'h028c_419d));
      rstn <= 1'b1;
      cmd_valid <= 1'b0;
      cmd <= '0;
      ext_intr <= 1'b0;
      timer_intr <= 1'b0;
      m_mode = MODE_M;
      m_mie = 1'b0;
      m_mpie = 1'b0;
      m_mpp = MODE_U;
      m_mie_reg = '0;
      m_mtvec = TRAP_BASE;
      m_mscratch = '0;
      m_mepc = '0;
      m_mcause = '0;
      m_mtval = '0;
      exp_resp = '0;
      exp_mode = MODE_M;
      test_name = "reset";
      repeat (16) @(posedge clk);
      rstn <= 1'b0;

      // read-modify-write forms on mscratch
      issue_cmd("mscratch write", OP_CSRRW, MSCRATCH, 5'd1, $urandom, random_pc());
      issue_cmd("mscratch set", OP_CSRRS, MSCRATCH, 5'd2, $urandom, random_pc());
      issue_cmd("mscratch clear", OP_CSRRC, MSCRATCH, 5'd3, $urandom, random_pc());
      issue_cmd("set with x0", OP_CSRRS, MSCRATCH, 5'd0, 32'hffff_ffff, random_pc());
      read_csr("mscratch after x0", MSCRATCH);
      uimm = 5'($urandom_range(31, 1));
      issue_cmd("mscratch write imm", OP_CSRRWI, MSCRATCH, uimm, {27'b0, uimm}, random_pc());
      uimm = 5'($urandom_range(31, 1));
      issue_cmd("mscratch set imm", OP_CSRRSI, MSCRATCH, uimm, {27'b0, uimm}, random_pc());
      uimm = 5'($urandom_range(31, 1));
      issue_cmd("mscratch clear imm", OP_CSRRCI, MSCRATCH, uimm, {27'b0, uimm}, random_pc());
      issue_cmd("clear with x0", OP_CSRRC, MSCRATCH, 5'd0, 32'hffff_ffff, random_pc());
      read_csr("mscratch final", MSCRATCH);

      // masks, reserved mtvec mode, bad address
      issue_cmd("mie all ones", OP_CSRRW, MIE, 5'd4, 32'hffff_ffff, random_pc());
      read_csr("mie readback", MIE);
      issue_cmd("mtvec mode 2", OP_CSRRW, MTVEC, 5'd5, random_pc() | 32'h2, random_pc());
      read_csr("mtvec unchanged", MTVEC);
      issue_cmd("unimplemented csr", OP_CSRRW, 12'h7c0, 5'd6, $urandom, random_pc());
      read_csr("mcause illegal", MCAUSE);
      read_csr("mtval instr", MTVAL);
      issue_cmd("illegal op", OP_ILLEGAL, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("misa", MISA);
      read_csr("mhartid", MHARTID);

      // ecall and mret between the two modes
      issue_cmd("ecall in m", OP_ECALL, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("mepc after ecall", MEPC);
      read_csr("mcause ecall m", MCAUSE);
      issue_cmd("mpp to u", OP_CSRRC, MSTATUS, 5'd7, 32'h0000_1800, random_pc());
      issue_cmd("mepc target", OP_CSRRW, MEPC, 5'd8, random_pc(), random_pc());
      issue_cmd("mret to u", OP_MRET, 12'h0, 5'd0, 32'h0, random_pc());
      issue_cmd("ecall in u", OP_ECALL, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("mcause ecall u", MCAUSE);
      issue_cmd("mret to u again", OP_MRET, 12'h0, 5'd0, 32'h0, random_pc());
      issue_cmd("mret in u", OP_MRET, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("mcause mret in u", MCAUSE);
      read_csr("mstatus after traps", MSTATUS);

      // timer alone and then both lines
      issue_cmd("meie and mtie", OP_CSRRW, MIE, 5'd9, 32'h0000_0880, random_pc());
      issue_cmd("mtvec vectored", OP_CSRRW, MTVEC, 5'd10,
                ($urandom & 32'hffff_ff00) | 32'h1, random_pc());
      issue_cmd("mstatus mie on", OP_CSRRS, MSTATUS, 5'd11, 32'h8, random_pc());
      @(posedge clk);
      timer_intr <= 1'b1;
      wait_cycles(2);
      issue_cmd("timer interrupt", OP_RETIRE, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("mcause timer", MCAUSE);
      read_csr("mstatus after timer", MSTATUS);
      @(posedge clk);
      ext_intr <= 1'b1;
      wait_cycles(2);
      issue_cmd("mstatus mie again", OP_CSRRS, MSTATUS, 5'd11, 32'h8, random_pc());
      issue_cmd("external wins", OP_RETIRE, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("mcause external", MCAUSE);
      read_csr("mepc external", MEPC);
      read_csr("mstatus after external", MSTATUS);
      @(posedge clk);
      ext_intr <= 1'b0;
      timer_intr <= 1'b0;
      wait_cycles(2);

      // counter distance and ebreak
      read_csr("mcycle first", MCYCLE);
      gap = $urandom_range(12, 1);
      wait_cycles(gap);
      read_csr("mcycle second", MCYCLE);
      read_csr("mcycleh", MCYCLEH);
      issue_cmd("ebreak", OP_EBREAK, 12'h0, 5'd0, 32'h0, random_pc());
      read_csr("mtval ebreak", MTVAL);
      issue_cmd("plain retire", OP_RETIRE, 12'h0, 5'd0, 32'h0, random_pc());

      wait_cycles(3);
      $display("Simulation passed");
      $finish;
   end

endmodule

/* hdl/priv_unit.sv */
module priv_unit #(
   parameter priv_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 cmd_valid,
   input  priv_pkg::sys_cmd_t   cmd,
   input  logic                 ext_intr,
   input  logic                 timer_intr,
   output logic                 resp_valid,
   output priv_pkg::sys_resp_t  resp,
   output priv_pkg::priv_mode_t mode
);
   import priv_pkg::*;

   logic         acc_valid;
   access_t      acc;
   csr_state_t   csr_state;
   trap_action_t action;

   // stage 1, csr read and write value
   csr_access u_access (
      .clk       (clk),
      .rstn      (rstn),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .csr_state (csr_state),
      .acc_valid (acc_valid),
      .acc       (acc)
   );

   // stage 2, trap decision
   trap_unit u_trap (
      .clk        (clk),
      .rstn       (rstn),
      .acc_valid  (acc_valid),
      .acc        (acc),
      .csr_state  (csr_state),
      .action     (action),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   // stage 3, state commit
   csr_file #(
      .MTVEC_RESET (MTVEC_RESET)
   ) u_file (
      .clk        (clk),
      .rstn       (rstn),
      .acc_valid  (acc_valid),
      .action     (action),
      .ext_intr   (ext_intr),
      .timer_intr (timer_intr),
      .csr_state  (csr_state),
      .mode       (mode)
   );

endmodule

/* hdl/trap_unit.sv */
module trap_unit (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   acc_valid,
   input  priv_pkg::access_t      acc,
   input  priv_pkg::csr_state_t   csr_state,
   output priv_pkg::trap_action_t action,
   output logic                   resp_valid,
   output priv_pkg::sys_resp_t    resp
);
   import priv_pkg::*;

   logic       irq_on;
   xlen_t      irq_pend;
   logic       irq_take;
   logic [4:0] irq_cause;
   logic       is_csr_op;
   logic       exc_take;
   logic [4:0] exc_cause;
   xlen_t      exc_tval;
   logic       take_trap;
   logic       take_mret;
   xlen_t      tvec_base;
   xlen_t      next_pc;

   ////////////////////////////////////////
   // interrupt pick
   ////////////////////////////////////////
   // user mode always takes machine interrupts
   assign irq_on   = (csr_state.mode == MODE_U) || csr_state.mstatus_mie;
   assign irq_pend = csr_state.mip & csr_state.mie;

   always_comb begin
      irq_take  = 1'b0;
      irq_cause = IRQ_EXT;
      if (irq_on) begin
         if (irq_pend[IRQ_EXT]) begin
            irq_take  = 1'b1;
            irq_cause = IRQ_EXT;
         end else if (irq_pend[IRQ_SOFT]) begin
            irq_take  = 1'b1;
            irq_cause = IRQ_SOFT;
         end else if (irq_pend[IRQ_TIMER]) begin
            irq_take  = 1'b1;
            irq_cause = IRQ_TIMER;
         end
      end
   end

   // command's own exception
   always_comb begin
      exc_take  = 1'b0;
      exc_cause = CAUSE_ILLEGAL;
      exc_tval  = acc.instr;
      case (acc.op)
         OP_CSRRW, OP_CSRRS, OP_CSRRC,
         OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: exc_take = !acc.csr_ok;
         OP_ILLEGAL: exc_take = 1'b1;
         OP_MRET:    exc_take = (csr_state.mode == MODE_U);
         OP_ECALL: begin
            exc_take  = 1'b1;
            exc_cause = (csr_state.mode == MODE_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
            exc_tval  = '0;
         end
         OP_EBREAK: begin
            exc_take  = 1'b1;
            exc_cause = CAUSE_BREAK;
            exc_tval  = '0;
         end
         default: ;
      endcase
   end

   assign is_csr_op = acc.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                     OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};

   assign take_trap = irq_take || exc_take;
   assign take_mret = !irq_take && acc.op == OP_MRET && csr_state.mode == MODE_M;

   always_comb begin
      action           = '0;
      action.kind      = take_trap ? ACT_TRAP : (take_mret ? ACT_MRET : ACT_NONE);
      action.is_irq    = irq_take;
      action.cause     = irq_take ? irq_cause : exc_cause;
      action.tval      = irq_take ? '0 : exc_tval;
      action.epc       = acc.pc;
      action.csr_we    = is_csr_op && acc.do_write && !take_trap;
      action.csr_addr  = acc.csr_addr;
      action.csr_wdata = acc.new_value;
   end

   ////////////////////////////////////////
   // next pc and response
   ////////////////////////////////////////
   assign tvec_base = {csr_state.mtvec[31:2], 2'b00};

   always_comb begin
      if (take_trap) begin
         // vectored mode only offsets interrupts
         if (irq_take && csr_state.mtvec[1:0] == 2'b01) begin
            next_pc = tvec_base + {25'b0, irq_cause, 2'b00};
         end else begin
            next_pc = tvec_base;
         end
      end else if (take_mret) begin
         next_pc = csr_state.mepc;
      end else begin
         next_pc = acc.pc + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= acc_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (acc_valid) begin
         resp.rd_data <= is_csr_op ? acc.old_value : '0;
         resp.next_pc <= next_pc;
         resp.trapped <= take_trap;
      end
   end

   a_trap_xor_mret: assert property (@(posedge clk) disable iff (rstn)
      acc_valid |-> !(take_trap && take_mret));

endmodule

/* csr/csr_file.sv */
module csr_file #(
   parameter priv_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   acc_valid,
   input  priv_pkg::trap_action_t action,
   input  logic                   ext_intr,
   input  logic                   timer_intr,
   output priv_pkg::csr_state_t   csr_state,
   output priv_pkg::priv_mode_t   mode
);
   import priv_pkg::*;

   priv_mode_t  mode_q;
   logic        st_mie;
   logic        st_mpie;
   priv_mode_t  st_mpp;
   xlen_t       mie_q;
   logic        msip;
   logic        meip;
   logic        mtip;
   xlen_t       mtvec_q;
   xlen_t       mscratch_q;
   xlen_t       mepc_q;
   xlen_t       mcause_q;
   xlen_t       mtval_q;
   logic [63:0] mcycle_q;

   xlen_t       st_wr;
   xlen_t       mie_wr;
   xlen_t       mip_wr;

   // masked views of the write data
   assign st_wr  = action.csr_wdata & MSTATUS_WMASK;
   assign mie_wr = action.csr_wdata & MIE_WMASK;
   assign mip_wr = action.csr_wdata & MIP_WMASK;

   ////////////////////////////////////////
   // counter and interrupt lines
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         mcycle_q <= '0;
         meip     <= 1'b0;
         mtip     <= 1'b0;
      end else begin
         mcycle_q <= mcycle_q + 64'd1;
         meip     <= ext_intr;
         mtip     <= timer_intr;
      end
   end

   ////////////////////////////////////////
   // commit of the stage 2 action
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         mode_q     <= MODE_M;
         st_mie     <= 1'b0;
         st_mpie    <= 1'b0;
         st_mpp     <= MODE_U;
         mie_q      <= '0;
         msip       <= 1'b0;
         mtvec_q    <= MTVEC_RESET;
         mscratch_q <= '0;
         mepc_q     <= '0;
         mcause_q   <= '0;
         mtval_q    <= '0;
      end else if (acc_valid) begin
         if (action.kind == ACT_TRAP) begin
            st_mpie  <= st_mie;
            st_mie   <= 1'b0;
            st_mpp   <= mode_q;
            mode_q   <= MODE_M;
            mepc_q   <= action.epc;
            mcause_q <= {action.is_irq, 26'b0, action.cause};
            mtval_q  <= action.tval;
         end else if (action.kind == ACT_MRET) begin
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
            mode_q  <= st_mpp;
            st_mpp  <= MODE_U;
         end else if (action.csr_we) begin
            case (action.csr_addr)
               MSTATUS: begin
                  st_mie  <= st_wr[3];
                  st_mpie <= st_wr[7];
                  // no supervisor, anything but M falls back to U
                  st_mpp  <= (st_wr[12:11] == 2'b11) ? MODE_M : MODE_U;
               end
               MIE:      mie_q      <= mie_wr;
               MIP:      msip       <= mip_wr[3];
               MTVEC: begin
                  // reserved mode encodings leave mtvec as is
                  if (action.csr_wdata[1:0] < 2'd2) begin
                     mtvec_q <= action.csr_wdata;
                  end
               end
               MSCRATCH: mscratch_q <= action.csr_wdata;
               MEPC:     mepc_q     <= action.csr_wdata;
               MCAUSE:   mcause_q   <= action.csr_wdata;
               MTVAL:    mtval_q    <= action.csr_wdata;
               // read-only and counter addresses drop the write
               default: ;
            endcase
         end
      end
   end

   assign csr_state.mode         = mode_q;
   assign csr_state.mstatus_mie  = st_mie;
   assign csr_state.mstatus_mpie = st_mpie;
   assign csr_state.mstatus_mpp  = st_mpp;
   assign csr_state.mie          = mie_q;
   assign csr_state.mip          = {20'b0, meip, 3'b0, mtip, 3'b0, msip, 3'b0};
   assign csr_state.mtvec        = mtvec_q;
   assign csr_state.mscratch     = mscratch_q;
   assign csr_state.mepc         = mepc_q;
   assign csr_state.mcause       = mcause_q;
   assign csr_state.mtval        = mtval_q;
   assign csr_state.mcycle       = mcycle_q;

   assign mode = mode_q;

   a_mode_legal: assert property (@(posedge clk) disable iff (rstn)
      mode_q inside {MODE_U, MODE_M});

endmodule

/* csr/csr_access.sv */
module csr_access (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 cmd_valid,
   input  priv_pkg::sys_cmd_t   cmd,
   input  priv_pkg::csr_state_t csr_state,
   output logic                 acc_valid,
   output priv_pkg::access_t    acc
);
   import priv_pkg::*;

   logic  csr_ok;
   xlen_t old_value;
   xlen_t new_value;
   logic  is_csr_op;
   logic  is_set_clr;
   logic  do_write;
   xlen_t mstatus_word;

   // mstatus as seen by software, other fields read as zero
   assign mstatus_word = {19'b0, csr_state.mstatus_mpp, 3'b0, csr_state.mstatus_mpie,
                          3'b0, csr_state.mstatus_mie, 3'b0};

   ////////////////////////////////////////
   // address decode and read
   ////////////////////////////////////////
   always_comb begin
      csr_ok    = 1'b1;
      old_value = '0;
      case (cmd.csr_addr)
         MSTATUS:   old_value = mstatus_word;
         MISA:      old_value = MISA_VALUE;
         MIE:       old_value = csr_state.mie;
         MTVEC:     old_value = csr_state.mtvec;
         MSCRATCH:  old_value = csr_state.mscratch;
         MEPC:      old_value = csr_state.mepc;
         MCAUSE:    old_value = csr_state.mcause;
         MTVAL:     old_value = csr_state.mtval;
         MIP:       old_value = csr_state.mip;
         MCYCLE:    old_value = csr_state.mcycle[31:0];
         MCYCLEH:   old_value = csr_state.mcycle[63:32];
         // id registers are all zero
         MVENDORID, MARCHID, MIMPID, MHARTID: old_value = '0;
         default:   csr_ok = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // write value
   ////////////////////////////////////////
   always_comb begin
      new_value = old_value;
      case (cmd.op)
         OP_CSRRW, OP_CSRRWI: new_value = cmd.src;
         OP_CSRRS, OP_CSRRSI: new_value = old_value | cmd.src;
         OP_CSRRC, OP_CSRRCI: new_value = old_value & ~cmd.src;
         default:             new_value = old_value;
      endcase
   end

   assign is_csr_op  = cmd.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                      OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
   assign is_set_clr = cmd.op inside {OP_CSRRS, OP_CSRRC, OP_CSRRSI, OP_CSRRCI};

   // set/clear with a zero source field only reads
   assign do_write = is_csr_op && !(is_set_clr && cmd.rs1_idx == 5'd0);

   always_ff @(posedge clk) begin
      if (rstn) begin
         acc_valid <= 1'b0;
      end else begin
         acc_valid <= cmd_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         acc.op        <= cmd.op;
         acc.pc        <= cmd.pc;
         acc.instr     <= cmd.instr;
         acc.csr_addr  <= cmd.csr_addr;
         acc.csr_ok    <= csr_ok;
         acc.old_value <= old_value;
         acc.new_value <= new_value;
         acc.do_write  <= do_write;
      end
   end

   // one command in flight, the next strobe waits for the response cycle
   a_one_in_flight: assert property (@(posedge clk) disable iff (rstn)
      cmd_valid |=> !cmd_valid);

endmodule

/* common/priv_pkg.sv */
package priv_pkg;

   ////////////////////////////////////////
   // basic types
   ////////////////////////////////////////
   typedef logic [31:0] xlen_t;
   typedef logic [11:0] csr_addr_t;

   // machine csr addresses
   localparam csr_addr_t MSTATUS   = 12'h300;
   localparam csr_addr_t MISA      = 12'h301;
   localparam csr_addr_t MIE       = 12'h304;
   localparam csr_addr_t MTVEC     = 12'h305;
   localparam csr_addr_t MSCRATCH  = 12'h340;
   localparam csr_addr_t MEPC      = 12'h341;
   localparam csr_addr_t MCAUSE    = 12'h342;
   localparam csr_addr_t MTVAL     = 12'h343;
   localparam csr_addr_t MIP       = 12'h344;
   localparam csr_addr_t MCYCLE    = 12'hb00;
   localparam csr_addr_t MCYCLEH   = 12'hb80;
   localparam csr_addr_t MVENDORID = 12'hf11;
   localparam csr_addr_t MARCHID   = 12'hf12;
   localparam csr_addr_t MIMPID    = 12'hf13;
   localparam csr_addr_t MHARTID   = 12'hf14;

   // writable bits: mie, mpie, mpp
   localparam xlen_t MSTATUS_WMASK = 32'h0000_1888;
   // meie, mtie, msie
   localparam xlen_t MIE_WMASK     = 32'h0000_0888;
   // only msip is software writable
   localparam xlen_t MIP_WMASK     = 32'h0000_0008;

   // mxl = 1, letters I and U
   localparam xlen_t MISA_VALUE = 32'h4010_0100;

   ////////////////////////////////////////
   // trap causes
   ////////////////////////////////////////
   localparam logic [4:0] CAUSE_ILLEGAL = 5'd2;
   localparam logic [4:0] CAUSE_BREAK   = 5'd3;
   localparam logic [4:0] CAUSE_ECALL_U = 5'd8;
   localparam logic [4:0] CAUSE_ECALL_M = 5'd11;

   // interrupt codes, also the mip/mie bit index
   localparam logic [4:0] IRQ_SOFT  = 5'd3;
   localparam logic [4:0] IRQ_TIMER = 5'd7;
   localparam logic [4:0] IRQ_EXT   = 5'd11;

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////
   typedef enum logic [1:0] {
      MODE_U = 2'd0,
      MODE_M = 2'd3
   } priv_mode_t;

   typedef enum logic [3:0] {
      OP_RETIRE  = 4'd0,
      OP_CSRRW   = 4'd1,
      OP_CSRRS   = 4'd2,
      OP_CSRRC   = 4'd3,
      OP_CSRRWI  = 4'd4,
      OP_CSRRSI  = 4'd5,
      OP_CSRRCI  = 4'd6,
      OP_ECALL   = 4'd7,
      OP_EBREAK  = 4'd8,
      OP_MRET    = 4'd9,
      OP_ILLEGAL = 4'd10
   } sys_op_t;

   typedef enum logic [1:0] {
      ACT_NONE = 2'd0,
      ACT_TRAP = 2'd1,
      ACT_MRET = 2'd2
   } act_kind_t;

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////
   // command from the sequencer
   typedef struct packed {
      sys_op_t    op;
      csr_addr_t  csr_addr;
      logic [4:0] rs1_idx;
      xlen_t      src;
      xlen_t      pc;
      xlen_t      instr;
   } sys_cmd_t;

   // stage 1 result
   typedef struct packed {
      sys_op_t   op;
      xlen_t     pc;
      xlen_t     instr;
      csr_addr_t csr_addr;
      logic      csr_ok;
      xlen_t     old_value;
      xlen_t     new_value;
      logic      do_write;
   } access_t;

   // architectural state seen by stages 1 and 2
   typedef struct packed {
      priv_mode_t  mode;
      logic        mstatus_mie;
      logic        mstatus_mpie;
      priv_mode_t  mstatus_mpp;
      xlen_t       mie;
      xlen_t       mip;
      xlen_t       mtvec;
      xlen_t       mscratch;
      xlen_t       mepc;
      xlen_t       mcause;
      xlen_t       mtval;
      logic [63:0] mcycle;
   } csr_state_t;

   // stage 2 decision, committed by the csr file
   typedef struct packed {
      act_kind_t  kind;
      logic       is_irq;
      logic [4:0] cause;
      xlen_t      tval;
      xlen_t      epc;
      logic       csr_we;
      csr_addr_t  csr_addr;
      xlen_t      csr_wdata;
   } trap_action_t;

   typedef struct packed {
      xlen_t rd_data;
      xlen_t next_pc;
      logic  trapped;
   } sys_resp_t;

endpackage
